// File: Bender.yml
package:
  name: divsqrt

sources:
  - src/divsqrt_cfg_pkg.sv
  - src/divsqrt_types_pkg.sv
  - src/divsqrt_pipe.sv
  - src/divsqrt_iter_unit.sv
  - src/divsqrt_multi.sv
  - src/divsqrt_top.sv
  - target: test
    files:
      - tests/divsqrt_tb.sv

// File: build.f
src/divsqrt_cfg_pkg.sv
src/divsqrt_types_pkg.sv
src/divsqrt_pipe.sv
src/divsqrt_iter_unit.sv
src/divsqrt_multi.sv
src/divsqrt_top.sv
tests/divsqrt_tb.sv

// File: src/divsqrt_cfg_pkg.sv
// Operand and tag widths, operation encoding and status flags of the divide/sqrt unit
package divsqrt_cfg_pkg;

  // --------------------
  // Word sizes
  // --------------------
  // Width of operands, quotient, root and remainder
  localparam int unsigned OperandWidth = 16;
  // Tag is carried along untouched
  localparam int unsigned TagWidth     = 4;

  typedef logic [OperandWidth-1:0] operand_t;
  typedef logic [TagWidth-1:0]     tag_t;

  // --------------------
  // Operations
  // --------------------
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } divsqrt_op_e;

  // --------------------
  // Status flags
  // --------------------
  localparam int unsigned StatusWidth   = 2;
  // Flag positions inside status_t
  localparam int unsigned StatusDivZero = 1;
  localparam int unsigned StatusInexact = 0;

  typedef logic [StatusWidth-1:0] status_t;

endpackage

// File: src/divsqrt_iter_unit.sv
// Iterative restoring divider and digit-by-digit square root core with kill
`timescale 1ns/1ps

module divsqrt_iter_unit
  import divsqrt_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     div_start_i,
  input  logic     sqrt_start_i,
  input  logic     kill_i,
  input  operand_t op_a_i,
  input  operand_t op_b_i,
  output logic     ready_o,
  output logic     done_o,
  output operand_t result_o,
  output operand_t rem_o,
  output status_t  status_o
);

  localparam int unsigned CntWidth  = $clog2(OperandWidth);
  // Room for the shifted remainder and the trial value
  localparam int unsigned WideWidth = OperandWidth + 2;

  typedef logic [CntWidth-1:0]  cnt_t;
  typedef logic [WideWidth-1:0] wide_t;

  typedef enum logic {IDLE, RUN} state_e;

  // --------------------
  // Control
  // --------------------
  state_e state_q, state_d;
  cnt_t   cnt_q, cnt_d;
  logic   done_q;
  logic   start, step_en, last_step;

  assign ready_o   = (state_q == IDLE);
  assign start     = (div_start_i | sqrt_start_i) & ready_o & ~kill_i;
  // First step is already done in the start cycle
  assign step_en   = start | (state_q == RUN);
  assign last_step = (state_q == RUN) & (cnt_q == '0) & ~kill_i;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      IDLE: begin
        if (start) begin
          state_d = RUN;
          // Steps left after the one taken on start, minus the final one
          cnt_d   = sqrt_start_i ? cnt_t'(OperandWidth/2 - 2) : cnt_t'(OperandWidth - 2);
        end
      end
      RUN: begin
        if (cnt_q == '0) begin
          state_d = IDLE;
        end else begin
          cnt_d = cnt_q - cnt_t'(1);
        end
      end
      default: state_d = IDLE;
    endcase
    // Abort wins over everything
    if (kill_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_q  <= last_step;
    end
  end

  // --------------------
  // Datapath
  // --------------------
  operand_t rem_q, acc_q, res_q, dvsr_q;
  logic     is_sqrt_q;
  status_t  status_q;
  operand_t rem_cur, acc_cur, res_cur, dvsr_cur;
  logic     is_sqrt_cur;
  wide_t    shifted, trial, diff;
  logic     take;
  operand_t rem_nxt, acc_nxt, res_nxt;

  // Start cycle works straight on the incoming operands
  assign rem_cur     = start ? '0           : rem_q;
  assign acc_cur     = start ? op_a_i       : acc_q;
  assign res_cur     = start ? '0           : res_q;
  assign dvsr_cur    = start ? op_b_i       : dvsr_q;
  assign is_sqrt_cur = start ? sqrt_start_i : is_sqrt_q;

  always_comb begin
    if (is_sqrt_cur) begin
      // Bring down two radicand bits, try root*4+1
      shifted = {rem_cur, acc_cur[OperandWidth-1 -: 2]};
      trial   = {res_cur, 2'b01};
      acc_nxt = acc_cur << 2;
    end else begin
      // Bring down one dividend bit, try the divisor
      shifted = {1'b0, rem_cur, acc_cur[OperandWidth-1]};
      trial   = {2'b00, dvsr_cur};
      acc_nxt = acc_cur << 1;
    end
    diff    = shifted - trial;
    take    = (shifted >= trial);
    // Remainder never outgrows a word here, b of zero included
    rem_nxt = take ? diff[OperandWidth-1:0] : shifted[OperandWidth-1:0];
    res_nxt = {res_cur[OperandWidth-2:0], take};
  end

  always_ff @(posedge clk_i) begin
    if (step_en) begin
      rem_q <= rem_nxt;
      acc_q <= acc_nxt;
      res_q <= res_nxt;
    end
    if (start) begin
      dvsr_q    <= op_b_i;
      is_sqrt_q <= sqrt_start_i;
    end
    // Flags from the final remainder
    if (last_step) begin
      status_q[StatusDivZero] <= ~is_sqrt_q & (dvsr_q == '0);
      status_q[StatusInexact] <= (rem_nxt != '0);
    end
  end

  assign done_o   = done_q;
  assign result_o = res_q;
  assign rem_o    = rem_q;
  assign status_o = status_q;

  // Control block may only start an idle core
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (div_start_i || sqrt_start_i) |-> ready_o)
    else $error("start pulse while core busy");

endmodule

// File: src/divsqrt_multi.sv
// Control FSM with tag and result hold registers around the iterative core
`timescale 1ns/1ps

module divsqrt_multi
  import divsqrt_cfg_pkg::*;
  import divsqrt_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  // Upstream
  input  divsqrt_req_t req_i,
  input  logic         in_valid_i,
  output logic         in_ready_o,
  input  logic         flush_i,
  // Downstream
  output divsqrt_rsp_t rsp_o,
  output logic         out_valid_o,
  input  logic         out_ready_i,
  // Operation in flight
  output logic         busy_o
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  // --------------------
  // Control FSM
  // --------------------
  state_e state_q, state_d;
  logic   in_ready, out_valid;
  logic   div_start, sqrt_start, op_starting;
  logic   unit_ready, unit_done;
  logic   hold_result;   // catch core outputs this cycle
  logic   data_is_held;  // hold register drives the output
  logic   unit_busy;

  always_comb begin
    state_d      = state_q;
    in_ready     = 1'b0;
    out_valid    = 1'b0;
    hold_result  = 1'b0;
    data_is_held = 1'b0;
    unit_busy    = 1'b0;
    unique case (state_q)
      IDLE: begin
        in_ready = unit_ready;
        if (in_valid_i && unit_ready) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        unit_busy = 1'b1;
        if (unit_done) begin
          out_valid = 1'b1;
          if (out_ready_i) begin
            // Result leaves now, next one may start in the same cycle
            in_ready = unit_ready;
            state_d  = (in_valid_i && unit_ready) ? BUSY : IDLE;
          end else begin
            hold_result = 1'b1;
            state_d     = HOLD;
          end
        end
      end
      HOLD: begin
        unit_busy    = 1'b1;
        data_is_held = 1'b1;
        out_valid    = 1'b1;
        if (out_ready_i) begin
          in_ready = unit_ready;
          state_d  = (in_valid_i && unit_ready) ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush drops whatever is in flight
    if (flush_i) begin
      unit_busy = 1'b0;
      out_valid = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Starts are steered by the op field, never during flush
  assign op_starting = in_valid_i & in_ready & ~flush_i;
  assign div_start   = op_starting & (req_i.op == OP_DIV);
  assign sqrt_start  = op_starting & (req_i.op == OP_SQRT);

  // Tag waits here while the core runs
  tag_t tag_q;

  always_ff @(posedge clk_i) begin
    if (op_starting) begin
      tag_q <= req_i.tag;
    end
  end

  // --------------------
  // Core
  // --------------------
  operand_t     unit_result, unit_rem;
  status_t      unit_status;
  divsqrt_rsp_t core_rsp, held_rsp_q;

  divsqrt_iter_unit i_iter_unit (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .div_start_i  ( div_start   ),
    .sqrt_start_i ( sqrt_start  ),
    .kill_i       ( flush_i     ),
    .op_a_i       ( req_i.op_a  ),
    .op_b_i       ( req_i.op_b  ),
    .ready_o      ( unit_ready  ),
    .done_o       ( unit_done   ),
    .result_o     ( unit_result ),
    .rem_o        ( unit_rem    ),
    .status_o     ( unit_status )
  );

  assign core_rsp = '{result: unit_result, rem: unit_rem, status: unit_status, tag: tag_q};

  // Hold register, loaded when downstream stalls at done
  always_ff @(posedge clk_i) begin
    if (hold_result) begin
      held_rsp_q <= core_rsp;
    end
  end

  // --------------------
  // Output select
  // --------------------
  assign rsp_o       = data_is_held ? held_rsp_q : core_rsp;
  assign out_valid_o = out_valid;
  assign in_ready_o  = in_ready;
  assign busy_o      = unit_busy;

  // Core only finishes an operation that this block is still waiting for
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    unit_done |-> (state_q == BUSY))
    else $error("core done outside BUSY");

endmodule

// File: src/divsqrt_pipe.sv
// Valid/ready register pipe with configurable depth, synchronous flush and busy flag
`timescale 1ns/1ps

module divsqrt_pipe #(
  parameter int unsigned NumRegs = 1,
  parameter type         DataT   = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,
  // Upstream handshake
  input  DataT data_i,
  input  logic valid_i,
  output logic ready_o,
  // Downstream handshake
  output DataT data_o,
  output logic valid_o,
  input  logic ready_i,
  // Any stage holds an item
  output logic busy_o
);

  // Entry i is the item after i register stages, entry 0 is the input
  DataT data_q      [NumRegs+1];
  logic valid_q     [NumRegs+1];
  logic stage_ready [NumRegs+1];

  assign data_q[0]  = data_i;
  assign valid_q[0] = valid_i;
  assign ready_o    = stage_ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic load;

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q[i+1];
    assign load           = stage_ready[i] & valid_q[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // Payload only moves with a real item
    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Ready comes in from downstream at the last entry
  assign stage_ready[NumRegs] = ready_i;
  assign data_o               = data_q[NumRegs];
  assign valid_o              = valid_q[NumRegs];

  // OR over the register stages, input entry excluded
  always_comb begin
    busy_o = 1'b0;
    for (int i = 1; i <= NumRegs; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

  // Stalled output must not change under the consumer
  assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    (valid_o && !ready_i) |=> $stable(data_o))
    else $error("pipe output changed while stalled");

endmodule

// File: src/divsqrt_top.sv
// Top level with input pipe, divide/sqrt control block, output pipe and busy flag
`timescale 1ns/1ps

module divsqrt_top
  import divsqrt_types_pkg::*;
#(
  parameter int unsigned NumInRegs  = 1,
  parameter int unsigned NumOutRegs = 1
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  divsqrt_req_t req_i,
  input  logic         in_valid_i,
  output logic         in_ready_o,
  output divsqrt_rsp_t rsp_o,
  output logic         out_valid_o,
  input  logic         out_ready_i,
  input  logic         flush_i,
  output logic         busy_o
);

  // Links between the three blocks
  divsqrt_req_t req_q;
  divsqrt_rsp_t rsp_d;
  logic         req_valid, req_ready;
  logic         rsp_valid, rsp_ready;
  logic         in_busy, core_busy, out_busy;

  // --------------------
  // Input side
  // --------------------
  divsqrt_pipe #(
    .NumRegs ( NumInRegs     ),
    .DataT   ( divsqrt_req_t )
  ) i_in_pipe (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .flush_i ( flush_i    ),
    .data_i  ( req_i      ),
    .valid_i ( in_valid_i ),
    .ready_o ( in_ready_o ),
    .data_o  ( req_q      ),
    .valid_o ( req_valid  ),
    .ready_i ( req_ready  ),
    .busy_o  ( in_busy    )
  );

  divsqrt_multi i_multi (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .req_i       ( req_q     ),
    .in_valid_i  ( req_valid ),
    .in_ready_o  ( req_ready ),
    .flush_i     ( flush_i   ),
    .rsp_o       ( rsp_d     ),
    .out_valid_o ( rsp_valid ),
    .out_ready_i ( rsp_ready ),
    .busy_o      ( core_busy )
  );

  // --------------------
  // Output side
  // --------------------
  divsqrt_pipe #(
    .NumRegs ( NumOutRegs    ),
    .DataT   ( divsqrt_rsp_t )
  ) i_out_pipe (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .flush_i ( flush_i     ),
    .data_i  ( rsp_d       ),
    .valid_i ( rsp_valid   ),
    .ready_o ( rsp_ready   ),
    .data_o  ( rsp_o       ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .busy_o  ( out_busy    )
  );

  // Anything still in flight anywhere
  assign busy_o = in_busy | core_busy | out_busy;

endmodule

// File: src/divsqrt_types_pkg.sv
// Request and response structs passed between the pipes and the control block
package divsqrt_types_pkg;

  import divsqrt_cfg_pkg::*;

  // --------------------
  // Upstream side
  // --------------------
  // One operation with its operands and tag
  // b is ignored for a square root
  typedef struct packed {
    operand_t    op_a;
    operand_t    op_b;
    divsqrt_op_e op;
    tag_t        tag;
  } divsqrt_req_t;

  // --------------------
  // Downstream side
  // --------------------
  // Quotient or root, remainder, flags and the tag of the request
  typedef struct packed {
    operand_t result;
    operand_t rem;
    status_t  status;
    tag_t     tag;
  } divsqrt_rsp_t;

endpackage

// File: tests/divsqrt_tb.sv
// Testbench for divsqrt_top with clock, reset, LFSR stimulus, reference model, checks and timeout
`timescale 1ns/1ps

module divsqrt_tb
  import divsqrt_cfg_pkg::*;
  import divsqrt_types_pkg::*;
;

  localparam int HalfPeriod  = 10;
  localparam int ResetCycles = 16;
  // Pipe depths of the DUT, which runs with its defaults
  localparam int NumInRegs   = 1;
  localparam int NumOutRegs  = 1;
  localparam int TotalOps    = 60 + 60 + 20 + 80 + 3 + 1;
  localparam int TimeoutCycles =
    ResetCycles + TotalOps * (OperandWidth + NumInRegs + NumOutRegs + 8) + 200;
  localparam int NumTests    = 6;
  // Kinds of requests that make_req produces
  localparam int ModeDiv     = 0;
  localparam int ModeSqrt    = 1;
  localparam int ModeDivZero = 2;
  localparam int ModeMixed   = 3;

  logic         clk_i, rst_n_i, in_valid_i, in_ready_o;
  logic         out_valid_o, out_ready_i, flush_i, busy_o;
  divsqrt_req_t req_i;
  divsqrt_rsp_t rsp_o;

  divsqrt_rsp_t exp_q[$];
  logic [31:0]  lfsr_state = 32'h72bf7fce;
  logic         req_taken, stall_seen;
  divsqrt_rsp_t stall_rsp;
  int           error_count, tests_passed, errs_before, issued, cycle_count;

  divsqrt_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(HalfPeriod) clk_i = ~clk_i;
  end

  // --------------------
  // Random numbers
  // --------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic divsqrt_req_t make_req(input int mode);
    divsqrt_req_t req;
    req.op_a = operand_t'(rand_bits(OperandWidth));
    req.op_b = operand_t'(rand_bits(OperandWidth));
    req.tag  = tag_t'(rand_bits(TagWidth));
    case (mode)
      ModeDiv: begin
        req.op = OP_DIV;
        // Small divisors give large quotients
        if (rand_bits(1)) begin
          req.op_b = req.op_b >> 8;
        end
      end
      ModeSqrt: req.op = OP_SQRT;
      ModeDivZero: begin
        req.op = OP_DIV;
        if (rand_bits(1)) begin
          req.op_b = '0;
        end
      end
      default: req.op = divsqrt_op_e'(rand_bits(1));
    endcase
    return req;
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic divsqrt_rsp_t model_rsp(input divsqrt_req_t req);
    divsqrt_rsp_t rsp;
    int unsigned  root;
    rsp.tag    = req.tag;
    rsp.status = '0;
    if (req.op == OP_SQRT) begin
      // Largest root whose square still fits under a
      root = 0;
      while ((root + 1) * (root + 1) <= req.op_a) begin
        root++;
      end
      rsp.result = operand_t'(root);
      rsp.rem    = req.op_a - operand_t'(root * root);
    end else if (req.op_b == '0) begin
      rsp.result = '1;
      rsp.rem    = req.op_a;
      rsp.status[StatusDivZero] = 1'b1;
    end else begin
      rsp.result = req.op_a / req.op_b;
      rsp.rem    = req.op_a % req.op_b;
    end
    rsp.status[StatusInexact] = (rsp.rem != '0);
    return rsp;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  // --------------------
  // Per-cycle monitor
  // --------------------
  // Samples 1 ns before the rising edge, where the handshake is decided
  task automatic observe_cycle();
    divsqrt_rsp_t exp_rsp;
    #(HalfPeriod - 1);
    if (stall_seen) begin
      if (!out_valid_o) begin
        $display("error at %0t ns: out_valid_o dropped before the response was taken", $time);
        error_count++;
      end else if (rsp_o !== stall_rsp) begin
        $display("mismatch at %0t ns: rsp_o changed while stalled", $time);
        error_count++;
      end
    end
    stall_seen = out_valid_o && !out_ready_i && !flush_i;
    stall_rsp  = rsp_o;
    if (out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t ns: response arrived with no request outstanding", $time);
        error_count++;
      end else begin
        exp_rsp = exp_q.pop_front();
        check_field("result", rsp_o.result, exp_rsp.result);
        check_field("rem", rsp_o.rem, exp_rsp.rem);
        check_field("status", rsp_o.status, exp_rsp.status);
        check_field("tag", rsp_o.tag, exp_rsp.tag);
      end
    end
    // Flushed requests never come back
    if (flush_i) begin
      exp_q.delete();
    end
    req_taken = in_valid_i && in_ready_o && !flush_i;
    if (req_taken) begin
      exp_q.push_back(model_rsp(req_i));
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      in_valid_i  = 1'b0;
      out_ready_i = 1'b1;
      flush_i     = 1'b0;
      observe_cycle();
    end
  endtask

  // Sends n requests and drains every response
  task automatic run_ops(input int n, input int mode, input bit pressure);
    int sent;
    sent      = 0;
    req_taken = 1'b0;
    while (sent < n || exp_q.size() != 0) begin
      @(negedge clk_i);
      flush_i = 1'b0;
      // Request stays put until it is taken
      if (!in_valid_i || req_taken) begin
        in_valid_i = 1'b0;
        if (sent < n && (!pressure || rand_bits(1))) begin
          req_i      = make_req(mode);
          in_valid_i = 1'b1;
        end
      end
      out_ready_i = pressure ? (rand_bits(2) != 0) : 1'b1;
      observe_cycle();
      if (req_taken) begin
        sent++;
      end
    end
    idle(1);
  endtask

  task automatic report_test(input int num, input string name);
    if (error_count == errs_before) begin
      tests_passed++;
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, error_count - errs_before);
    end
    errs_before = error_count;
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    req_i       = '0;
    out_ready_i = 1'b1;
    flush_i     = 1'b0;
    stall_seen  = 1'b0;
    req_taken   = 1'b0;
    error_count = 0;
    errs_before = 0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_n_i = 1'b1;

    @(negedge clk_i);
    observe_cycle();
    check_field("out_valid_o", out_valid_o, 1'b0);
    check_field("busy_o", busy_o, 1'b0);
    check_field("in_ready_o", in_ready_o, 1'b1);
    report_test(1, "reset state");

    run_ops(60, ModeDiv, 1'b0);
    report_test(2, "random division");
    run_ops(60, ModeSqrt, 1'b0);
    report_test(3, "random square root");
    run_ops(20, ModeDivZero, 1'b0);
    report_test(4, "divide by zero");
    run_ops(80, ModeMixed, 1'b1);
    report_test(5, "back-pressure");

    // Three divisions, the first one drains, the rest get flushed
    issued = 0;
    while (issued < 3) begin
      @(negedge clk_i);
      if (!in_valid_i || req_taken) begin
        req_i      = make_req(ModeDiv);
        in_valid_i = 1'b1;
      end
      observe_cycle();
      if (req_taken) begin
        issued++;
      end
    end
    idle(4);
    @(negedge clk_i);
    flush_i = 1'b1;
    observe_cycle();
    @(negedge clk_i);
    flush_i = 1'b0;
    observe_cycle();
    check_field("busy_o", busy_o, 1'b0);
    // Any response here has nothing left in the model queue
    idle(40);
    run_ops(1, ModeDiv, 1'b0);
    report_test(6, "flush");

    $display("summary: %0d of %0d tests passed, %0d errors", tests_passed, NumTests, error_count);
    if (error_count == 0 && tests_passed == NumTests) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Hard limit on run length
  initial begin
    cycle_count = 0;
    while (cycle_count <= TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
